//--- lsu_defines.svh
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Read latency of the line memory in cycles
`define LSU_MEM_LAT 5

// Line geometry, 256 lines of 128 bits
`define LSU_LINE_BITS 128
`define LSU_LINE_COUNT 256

`endif

//--- isa_pkg.sv
package isa_pkg;

    typedef logic [31:0] word_t;

    typedef enum logic [6:0] {
        LOAD  = 7'b0000011,
        STORE = 7'b0100011
    } opcode_e;

    typedef enum logic [2:0] {
        F3_B  = 3'b000,
        F3_H  = 3'b001,
        F3_W  = 3'b010,
        F3_BU = 3'b100,
        F3_HU = 3'b101
    } funct3_e;

    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } size_e;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        funct3_e     funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } itype_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        funct3_e    funct3;
        logic [4:0] imm_lo;
        opcode_e    opcode;
    } stype_t;

    // Same word, seen as load or store format
    typedef union packed {
        itype_t i;
        stype_t s;
    } instr_u;

    typedef struct packed {
        logic       valid;
        logic       is_store;
        logic       illegal;
        size_e      size;
        logic       unsigned_ld;
        logic [4:0] rd;
        word_t      base;
        word_t      offset;
        word_t      store_data;
    } lsu_op_t;

endpackage

//--- mem_pkg.sv
`include "lsu_defines.svh"

package mem_pkg;

    typedef logic [`LSU_LINE_BITS-1:0] line_t;

    typedef struct packed {
        logic [31:4]                 line_addr;
        logic                        we;
        logic [`LSU_LINE_BITS/8-1:0] be;
        line_t                       wdata;
    } mem_req_t;

    typedef struct packed {
        logic [31:4] line_addr;
        line_t       data;
    } mem_rsp_t;

    typedef struct packed {
        logic [4:0]     rd;
        logic           is_store;
        logic           illegal;
        logic           misaligned;
        isa_pkg::word_t data;
    } lsu_cpl_t;

    // Held by execute until the memory response comes back
    typedef struct packed {
        logic           [4:0] rd;
        logic                 is_store;
        isa_pkg::size_e       size;
        logic                 unsigned_ld;
        logic           [3:0] offset;
    } lsu_pend_t;

endpackage

//--- lsu_decode.sv
`timescale 1ns/1ns

module lsu_decode (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              instr_valid_i,
    input  isa_pkg::instr_u   instr_i,
    input  isa_pkg::word_t    rs1_val_i,
    input  isa_pkg::word_t    rs2_val_i,
    input  logic              cpl_done_i,
    output logic              instr_ready_o,
    output isa_pkg::lsu_op_t  op_o
);

    logic             busy_q;
    logic             accept;
    isa_pkg::lsu_op_t op_d;

    assign instr_ready_o = ~busy_q;
    assign accept        = instr_valid_i & ~busy_q;

    always_comb begin
        op_d            = '0;
        op_d.valid      = accept;
        op_d.base       = rs1_val_i;
        op_d.store_data = rs2_val_i;
        op_d.size       = isa_pkg::WORD;

        case (instr_i.i.opcode)
            isa_pkg::LOAD: begin
                op_d.rd     = instr_i.i.rd;
                op_d.offset = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
                case (instr_i.i.funct3)
                    isa_pkg::F3_B:  op_d.size = isa_pkg::BYTE;
                    isa_pkg::F3_H:  op_d.size = isa_pkg::HALF;
                    isa_pkg::F3_W:  op_d.size = isa_pkg::WORD;
                    isa_pkg::F3_BU: begin
                        op_d.size        = isa_pkg::BYTE;
                        op_d.unsigned_ld = 1'b1;
                    end
                    isa_pkg::F3_HU: begin
                        op_d.size        = isa_pkg::HALF;
                        op_d.unsigned_ld = 1'b1;
                    end
                    default: op_d.illegal = 1'b1;
                endcase
            end
            isa_pkg::STORE: begin
                // Split immediate, rd field holds imm[4:0]
                op_d.is_store = 1'b1;
                op_d.offset   = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi,
                                 instr_i.s.imm_lo};
                case (instr_i.s.funct3)
                    isa_pkg::F3_B: op_d.size = isa_pkg::BYTE;
                    isa_pkg::F3_H: op_d.size = isa_pkg::HALF;
                    isa_pkg::F3_W: op_d.size = isa_pkg::WORD;
                    default:       op_d.illegal = 1'b1;
                endcase
            end
            default: op_d.illegal = 1'b1;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            busy_q <= 1'b0;
            op_o   <= '0;
        end else begin
            op_o <= op_d;
            if (accept) begin
                busy_q <= 1'b1;
            end else if (cpl_done_i) begin
                busy_q <= 1'b0;
            end
        end
    end

endmodule

//--- lsu_execute.sv
`timescale 1ns/1ns

module lsu_execute (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  isa_pkg::lsu_op_t    op_i,
    output logic                mem_req_valid_o,
    output mem_pkg::mem_req_t   mem_req_o,
    output mem_pkg::lsu_pend_t  pend_o,
    output logic                fault_valid_o,
    output mem_pkg::lsu_cpl_t   fault_cpl_o
);

    isa_pkg::word_t     addr;
    logic               misaligned;
    logic               fault;
    logic [15:0]        be_base;
    mem_pkg::mem_req_t  req_d;
    mem_pkg::lsu_pend_t pend_d;
    mem_pkg::lsu_cpl_t  fault_d;

    always_comb begin
        addr = op_i.base + op_i.offset;

        case (op_i.size)
            isa_pkg::HALF: begin
                misaligned = addr[0];
                be_base    = 16'h0003;
            end
            isa_pkg::WORD: begin
                misaligned = |addr[1:0];
                be_base    = 16'h000F;
            end
            default: begin
                misaligned = 1'b0;
                be_base    = 16'h0001;
            end
        endcase

        // Illegal takes priority over the alignment flag
        if (op_i.illegal) begin
            misaligned = 1'b0;
        end
        fault = op_i.illegal | misaligned;

        req_d.line_addr = addr[31:4];
        req_d.we        = op_i.is_store;
        req_d.be        = op_i.is_store ? be_base << addr[3:0] : '0;
        req_d.wdata     = mem_pkg::line_t'(op_i.store_data) << {addr[3:0], 3'b000};

        pend_d.rd          = op_i.rd;
        pend_d.is_store    = op_i.is_store;
        pend_d.size        = op_i.size;
        pend_d.unsigned_ld = op_i.unsigned_ld;
        pend_d.offset      = addr[3:0];

        fault_d.rd         = op_i.rd;
        fault_d.is_store   = op_i.is_store;
        fault_d.illegal    = op_i.illegal;
        fault_d.misaligned = misaligned;
        fault_d.data       = '0;
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            mem_req_valid_o <= 1'b0;
            mem_req_o       <= '0;
            pend_o          <= '0;
            fault_valid_o   <= 1'b0;
            fault_cpl_o     <= '0;
        end else begin
            mem_req_valid_o <= op_i.valid & ~fault;
            fault_valid_o   <= op_i.valid & fault;
            mem_req_o       <= req_d;
            fault_cpl_o     <= fault_d;
            // Kept until the response returns
            if (op_i.valid) begin
                pend_o <= pend_d;
            end
        end
    end

endmodule

//--- line_memory.sv
`timescale 1ns/1ns
`include "lsu_defines.svh"

module line_memory (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic               req_valid_i,
    input  mem_pkg::mem_req_t  req_i,
    output logic               rsp_valid_o,
    output mem_pkg::mem_rsp_t  rsp_o
);

    localparam int LAT   = `LSU_MEM_LAT;
    localparam int BYTES = `LSU_LINE_BITS / 8;
    localparam int IDX_W = $clog2(`LSU_LINE_COUNT);

    mem_pkg::line_t    mem_q [`LSU_LINE_COUNT];
    logic [IDX_W-1:0]  idx;
    mem_pkg::line_t    line_rd;
    mem_pkg::line_t    line_wr;
    logic              valid_pipe [LAT];
    mem_pkg::mem_rsp_t rsp_pipe [LAT];

    // Addresses wrap with the line count
    assign idx = req_i.line_addr[4 +: IDX_W];

    always_comb begin
        line_rd = mem_q[idx];
        line_wr = line_rd;
        for (int b = 0; b < BYTES; b++) begin
            if (req_i.be[b]) begin
                line_wr[b*8 +: 8] = req_i.wdata[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < `LSU_LINE_COUNT; i++) begin
                mem_q[i] <= '0;
            end
        end else if (req_valid_i && req_i.we) begin
            mem_q[idx] <= line_wr;
        end
    end

    // Fixed-latency delay chain, stores return the merged line
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < LAT; i++) begin
                valid_pipe[i] <= 1'b0;
                rsp_pipe[i]   <= '0;
            end
        end else begin
            valid_pipe[0]          <= req_valid_i;
            rsp_pipe[0].line_addr  <= req_i.line_addr;
            rsp_pipe[0].data       <= req_i.we ? line_wr : line_rd;
            for (int i = 1; i < LAT; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
                rsp_pipe[i]   <= rsp_pipe[i-1];
            end
        end
    end

    assign rsp_valid_o = valid_pipe[LAT-1];
    assign rsp_o       = rsp_pipe[LAT-1];

endmodule

//--- lsu_result.sv
`timescale 1ns/1ns

module lsu_result (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                rsp_valid_i,
    input  mem_pkg::mem_rsp_t   rsp_i,
    input  mem_pkg::lsu_pend_t  pend_i,
    input  logic                fault_valid_i,
    input  mem_pkg::lsu_cpl_t   fault_cpl_i,
    output logic                cpl_valid_o,
    output mem_pkg::lsu_cpl_t   cpl_o
);

    mem_pkg::line_t    line_sh;
    isa_pkg::word_t    raw;
    isa_pkg::word_t    ld_data;
    mem_pkg::lsu_cpl_t mem_cpl;

    always_comb begin
        // Addressed bytes down to bit 0
        line_sh = rsp_i.data >> {pend_i.offset, 3'b000};
        raw     = line_sh[31:0];

        case (pend_i.size)
            isa_pkg::BYTE: begin
                ld_data = pend_i.unsigned_ld ? {24'b0, raw[7:0]}
                                             : {{24{raw[7]}}, raw[7:0]};
            end
            isa_pkg::HALF: begin
                ld_data = pend_i.unsigned_ld ? {16'b0, raw[15:0]}
                                             : {{16{raw[15]}}, raw[15:0]};
            end
            default: ld_data = raw;
        endcase

        mem_cpl.rd         = pend_i.rd;
        mem_cpl.is_store   = pend_i.is_store;
        mem_cpl.illegal    = 1'b0;
        mem_cpl.misaligned = 1'b0;
        mem_cpl.data       = pend_i.is_store ? '0 : ld_data;
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cpl_valid_o <= 1'b0;
            cpl_o       <= '0;
        end else begin
            cpl_valid_o <= rsp_valid_i | fault_valid_i;
            cpl_o       <= fault_valid_i ? fault_cpl_i : mem_cpl;
        end
    end

endmodule

//--- lsu_top.sv
`timescale 1ns/1ns

module lsu_top (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic               instr_valid_i,
    input  isa_pkg::instr_u    instr_i,
    input  isa_pkg::word_t     rs1_val_i,
    input  isa_pkg::word_t     rs2_val_i,
    output logic               instr_ready_o,
    output logic               cpl_valid_o,
    output mem_pkg::lsu_cpl_t  cpl_o
);

    isa_pkg::lsu_op_t   op;
    logic               mem_req_valid;
    mem_pkg::mem_req_t  mem_req;
    mem_pkg::lsu_pend_t pend;
    logic               fault_valid;
    mem_pkg::lsu_cpl_t  fault_cpl;
    logic               mem_rsp_valid;
    mem_pkg::mem_rsp_t  mem_rsp;

    lsu_decode i_lsu_decode (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rs1_val_i     (rs1_val_i),
        .rs2_val_i     (rs2_val_i),
        .cpl_done_i    (cpl_valid_o),
        .instr_ready_o (instr_ready_o),
        .op_o          (op)
    );

    lsu_execute i_lsu_execute (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .op_i            (op),
        .mem_req_valid_o (mem_req_valid),
        .mem_req_o       (mem_req),
        .pend_o          (pend),
        .fault_valid_o   (fault_valid),
        .fault_cpl_o     (fault_cpl)
    );

    line_memory i_line_memory (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .req_valid_i (mem_req_valid),
        .req_i       (mem_req),
        .rsp_valid_o (mem_rsp_valid),
        .rsp_o       (mem_rsp)
    );

    lsu_result i_lsu_result (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .rsp_valid_i   (mem_rsp_valid),
        .rsp_i         (mem_rsp),
        .pend_i        (pend),
        .fault_valid_i (fault_valid),
        .fault_cpl_i   (fault_cpl),
        .cpl_valid_o   (cpl_valid_o),
        .cpl_o         (cpl_o)
    );

endmodule

//--- tb_lsu.sv
`timescale 1ns/1ns
`include "lsu_defines.svh"

module tb_lsu;

    localparam int RESET_CYCLES = 16;
    localparam int CPL_TIMEOUT  = 20;
    localparam int RAND_OPS     = 40;
    localparam int NUM_OPS      = 3 + 4 + 100 + RAND_OPS + 14 + 3;
    // Clock edges after acceptance until cpl_valid_o is sampled high
    localparam int MEM_CYCLES   = `LSU_MEM_LAT + 2;
    localparam int FAULT_CYCLES = 2;

    // RISC-V encodings
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM = 7'b0010011;
    localparam logic [2:0] F3_B      = 3'b000;
    localparam logic [2:0] F3_H      = 3'b001;
    localparam logic [2:0] F3_W      = 3'b010;
    localparam logic [2:0] F3_BU     = 3'b100;
    localparam logic [2:0] F3_HU     = 3'b101;

    logic              clk;
    logic              rstn;
    logic              instr_valid;
    isa_pkg::instr_u   instr;
    isa_pkg::word_t    rs1_val;
    isa_pkg::word_t    rs2_val;
    logic              instr_ready;
    logic              cpl_valid;
    mem_pkg::lsu_cpl_t cpl;

    logic [7:0]  ref_mem [4096];
    logic [15:0] lfsr_q = 16'd24292;

    lsu_top i_lsu_top (
        .clk_i         (clk),
        .rstn_i        (rstn),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .rs1_val_i     (rs1_val),
        .rs2_val_i     (rs2_val),
        .instr_ready_o (instr_ready),
        .cpl_valid_o   (cpl_valid),
        .cpl_o         (cpl)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic lfsr_step();
        logic out;
        out    = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (out) begin
            lfsr_q = lfsr_q ^ 16'hB400;
        end
        return out;
    endfunction

    function automatic isa_pkg::word_t rand_bits(input int n);
        isa_pkg::word_t v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    function automatic isa_pkg::instr_u enc_itype(input logic [6:0] opc, input logic [2:0] f3,
                                                  input logic [4:0] rd, input logic [11:0] imm);
        return {imm, 5'd1, f3, rd, opc};
    endfunction

    function automatic isa_pkg::instr_u enc_stype(input logic [2:0] f3, input logic [11:0] imm);
        return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], OPC_STORE};
    endfunction

    task automatic stop_with_failure();
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input isa_pkg::word_t got,
                                   input isa_pkg::word_t exp);
        $display("MISMATCH time=%0t signal=%s got=0x%08h expected=0x%08h", $time, name, got, exp);
        stop_with_failure();
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_mismatch(name, {31'b0, got}, {31'b0, exp});
        end
    endtask

    task automatic compare_word(input string name, input isa_pkg::word_t got,
                                input isa_pkg::word_t exp);
        if (got !== exp) begin
            report_mismatch(name, got, exp);
        end
    endtask

    task automatic compare_cpl(input mem_pkg::lsu_cpl_t got, input mem_pkg::lsu_cpl_t exp);
        compare_word("cpl_o.rd", {27'b0, got.rd}, {27'b0, exp.rd});
        compare_flag("cpl_o.is_store", got.is_store, exp.is_store);
        compare_flag("cpl_o.illegal", got.illegal, exp.illegal);
        compare_flag("cpl_o.misaligned", got.misaligned, exp.misaligned);
        compare_word("cpl_o.data", got.data, exp.data);
    endtask

    task automatic issue_op(input isa_pkg::instr_u op_word, input isa_pkg::word_t base,
                            input isa_pkg::word_t data);
        int waited;
        waited = 0;
        while (!instr_ready) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited >= CPL_TIMEOUT) begin
                $display("ERROR: instr_ready_o stayed low for %0d cycles before issue", waited);
                stop_with_failure();
            end
        end
        instr_valid = 1'b1;
        instr       = op_word;
        rs1_val     = base;
        rs2_val     = data;
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        compare_flag("instr_ready_o after accept", instr_ready, 1'b0);
    endtask

    task automatic wait_cpl(output mem_pkg::lsu_cpl_t got, output int cycles);
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
            compare_flag("instr_ready_o while busy", instr_ready, 1'b0);
            if (!cpl_valid && cycles >= CPL_TIMEOUT) begin
                $display("ERROR: no completion within %0d cycles of acceptance", CPL_TIMEOUT);
                stop_with_failure();
            end
        end while (!cpl_valid);
        got = cpl;
    endtask

    // Issues one instruction and checks it against the reference memory
    task automatic run_op(input isa_pkg::instr_u op_word, input isa_pkg::word_t base,
                          input isa_pkg::word_t data);
        isa_pkg::word_t    raw;
        isa_pkg::word_t    imm_x;
        isa_pkg::word_t    addr;
        isa_pkg::word_t    a;
        isa_pkg::word_t    val;
        logic [2:0]        f3;
        logic              legal;
        logic              is_st;
        logic              mis;
        int                nbytes;
        int                cycles;
        mem_pkg::lsu_cpl_t exp_cpl;
        mem_pkg::lsu_cpl_t got_cpl;
        raw     = op_word;
        f3      = raw[14:12];
        is_st   = (raw[6:0] == OPC_STORE);
        exp_cpl = '0;
        val     = '0;
        if (raw[6:0] == OPC_LOAD) begin
            legal      = f3 inside {F3_B, F3_H, F3_W, F3_BU, F3_HU};
            imm_x      = {{20{raw[31]}}, raw[31:20]};
            exp_cpl.rd = raw[11:7];
        end else if (is_st) begin
            legal = f3 inside {F3_B, F3_H, F3_W};
            imm_x = {{20{raw[31]}}, raw[31:25], raw[11:7]};
        end else begin
            legal = 1'b0;
            imm_x = '0;
        end
        nbytes = 1 << f3[1:0];
        addr   = base + imm_x;
        mis    = legal && ((nbytes == 2 && addr[0]) || (nbytes == 4 && addr[1:0] != 2'b00));
        exp_cpl.is_store   = is_st;
        exp_cpl.illegal    = !legal;
        exp_cpl.misaligned = mis;
        if (legal && !mis) begin
            for (int k = 0; k < nbytes; k++) begin
                a = addr + k;
                if (is_st) begin
                    ref_mem[a[11:0]] = data[8*k +: 8];
                end else begin
                    val[8*k +: 8] = ref_mem[a[11:0]];
                end
            end
            if (!f3[2] && nbytes == 1) begin
                val = {{24{val[7]}}, val[7:0]};
            end else if (!f3[2] && nbytes == 2) begin
                val = {{16{val[15]}}, val[15:0]};
            end
            exp_cpl.data = is_st ? '0 : val;
        end
        issue_op(op_word, base, data);
        wait_cpl(got_cpl, cycles);
        compare_cpl(got_cpl, exp_cpl);
        compare_word("completion latency", cycles, (legal && !mis) ? MEM_CYCLES : FAULT_CYCLES);
        @(posedge clk);
        #1;
        compare_flag("cpl_valid_o after completion", cpl_valid, 1'b0);
        compare_flag("instr_ready_o after completion", instr_ready, 1'b1);
    endtask

    task automatic do_load(input logic [2:0] f3, input logic [4:0] rd,
                           input isa_pkg::word_t base, input logic [11:0] imm);
        run_op(enc_itype(OPC_LOAD, f3, rd, imm), base, rand_bits(32));
    endtask

    task automatic do_store(input logic [2:0] f3, input isa_pkg::word_t base,
                            input logic [11:0] imm, input isa_pkg::word_t data);
        run_op(enc_stype(f3, imm), base, data);
    endtask

    task automatic test_reset_state();
        compare_flag("instr_ready_o after reset", instr_ready, 1'b1);
        compare_flag("cpl_valid_o after reset", cpl_valid, 1'b0);
        do_load(F3_W, 5'd1, 32'h0000_0000, 12'h000);
        do_load(F3_W, 5'd2, 32'h0000_0800, 12'hFFC);
        do_load(F3_W, 5'd3, 32'h1234_5FF0, 12'h01C);
    endtask

    task automatic test_word_store_load();
        do_store(F3_W, 32'h0000_0040, 12'h000, 32'h1234_5678);
        do_load(F3_W, 5'd4, 32'h0000_0050, 12'hFF0);
        // Wraps past the top of the 4 KiB space
        do_store(F3_W, 32'h0000_0FFC, 12'h008, 32'h8765_4321);
        do_load(F3_W, 5'd5, 32'h0000_0004, 12'h000);
    endtask

    task automatic test_byte_half_lanes();
        isa_pkg::word_t lane_base;
        lane_base = 32'h0000_0100;
        for (int w = 0; w < 4; w++) begin
            do_store(F3_W, lane_base, 12'(4 * w), rand_bits(32));
        end
        for (int off = 0; off < 16; off++) begin
            do_store(F3_B, lane_base + off, 12'h000, rand_bits(32));
            do_load(F3_B, 5'd6, lane_base, 12'(off));
            do_load(F3_BU, 5'd7, lane_base, 12'(off));
            do_load(F3_W, 5'd8, lane_base, 12'(off & ~3));
        end
        for (int off = 0; off < 16; off += 2) begin
            do_store(F3_H, lane_base + off, 12'h000, rand_bits(32));
            do_load(F3_H, 5'd9, lane_base, 12'(off));
            do_load(F3_HU, 5'd10, lane_base, 12'(off));
            do_load(F3_W, 5'd11, lane_base, 12'(off & ~3));
        end
    endtask

    task automatic test_random_ops();
        isa_pkg::word_t sel;
        isa_pkg::word_t hi;
        isa_pkg::word_t lo;
        isa_pkg::word_t imm_w;
        isa_pkg::word_t rd_w;
        isa_pkg::word_t data;
        isa_pkg::word_t addr;
        isa_pkg::word_t base;
        logic [1:0]     sz;
        logic [2:0]     f3;
        for (int n = 0; n < RAND_OPS; n++) begin
            sel   = rand_bits(4);
            hi    = rand_bits(20);
            lo    = rand_bits(6);
            imm_w = rand_bits(12);
            rd_w  = rand_bits(5);
            data  = rand_bits(32);
            sz    = (sel[2:1] == 2'd3) ? 2'd2 : sel[2:1];
            f3    = {sel[3] && sz != 2'd2 && !sel[0], sz};
            // Window around the 4 KiB boundary so loads hit earlier stores
            addr = {hi[19:0], 12'hFE0 + {6'b0, lo[5:0]}};
            if (sz == 2'd1) begin
                addr[0] = 1'b0;
            end else if (sz == 2'd2) begin
                addr[1:0] = 2'b00;
            end
            base = addr - {{20{imm_w[11]}}, imm_w[11:0]};
            if (sel[0]) begin
                do_store(f3, base, imm_w[11:0], data);
            end else begin
                do_load(f3, rd_w[4:0], base, imm_w[11:0]);
            end
        end
    endtask

    task automatic test_faults();
        do_store(F3_W, 32'h0000_0200, 12'h000, 32'h1357_9BDF);
        do_store(F3_W, 32'h0000_0200, 12'h004, 32'h2468_ACE0);
        do_load(F3_H, 5'd12, 32'h0000_0200, 12'h001);
        do_load(F3_W, 5'd12, 32'h0000_0200, 12'h002);
        do_load(F3_HU, 5'd12, 32'h0000_0203, 12'h000);
        do_store(F3_H, 32'h0000_0201, 12'h000, 32'hFFFF_FFFF);
        do_store(F3_W, 32'h0000_0206, 12'h000, 32'hFFFF_FFFF);
        do_load(3'b011, 5'd13, 32'h0000_0200, 12'h000);
        do_load(3'b110, 5'd13, 32'h0000_0200, 12'h000);
        do_store(3'b011, 32'h0000_0200, 12'h000, 32'hFFFF_FFFF);
        do_store(3'b100, 32'h0000_0204, 12'h000, 32'hFFFF_FFFF);
        run_op(enc_itype(OPC_OPIMM, 3'b000, 5'd14, 12'h200), 32'h0, 32'hFFFF_FFFF);
        do_load(F3_W, 5'd15, 32'h0000_0200, 12'h000);
        do_load(F3_W, 5'd15, 32'h0000_0200, 12'h004);
    endtask

    task automatic test_held_valid();
        mem_pkg::lsu_cpl_t exp_cpl;
        int                cpl_count;
        do_store(F3_W, 32'h0000_0300, 12'h000, 32'hA5C3_0F96);
        instr_valid = 1'b1;
        instr       = enc_itype(OPC_LOAD, F3_W, 5'd16, 12'h000);
        rs1_val     = 32'h0000_0300;
        rs2_val     = 32'h0;
        @(posedge clk);
        #1;
        compare_flag("instr_ready_o after accept", instr_ready, 1'b0);
        // A different store held while busy must never be taken
        instr     = enc_stype(F3_W, 12'h000);
        rs2_val   = 32'hDEAD_BEEF;
        exp_cpl   = '0;
        exp_cpl.rd   = 5'd16;
        exp_cpl.data = 32'hA5C3_0F96;
        cpl_count = 0;
        for (int k = 0; k < CPL_TIMEOUT; k++) begin
            @(posedge clk);
            #1;
            if (cpl_valid) begin
                cpl_count++;
                compare_cpl(cpl, exp_cpl);
                instr_valid = 1'b0;
            end else if (instr_valid) begin
                compare_flag("instr_ready_o while held", instr_ready, 1'b0);
            end
        end
        compare_word("completions for one held instruction", cpl_count, 1);
        do_load(F3_W, 5'd17, 32'h0000_0300, 12'h000);
    endtask

    initial begin
        repeat (RESET_CYCLES + NUM_OPS * 20 + 100) @(posedge clk);
        $display("ERROR: watchdog expired before all tests finished");
        stop_with_failure();
    end

    initial begin
        rstn        = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        rs1_val     = '0;
        rs2_val     = '0;
        ref_mem     = '{default: 8'h00};
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rstn = 1'b1;
        @(posedge clk);
        #1;
        test_reset_state();
        test_word_store_load();
        test_byte_half_lanes();
        test_random_ops();
        test_faults();
        test_held_valid();
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+.
isa_pkg.sv
mem_pkg.sv
lsu_decode.sv
lsu_execute.sv
line_memory.sv
lsu_result.sv
lsu_top.sv
tb_lsu.sv

//--- run.sh
#!/bin/sh
# Builds the LSU testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing \
    -f filelist.f \
    --top-module tb_lsu \
    --Mdir obj_dir

./obj_dir/Vtb_lsu
